//--- verilog/pwm_pkg.sv
/*
 * Shared definitions for the two-channel PWM peripheral: bus widths,
 * the per-channel register map and the decoded view of the config word.
 * Modules refer to these by scoped name.
 */

package pwm_pkg;

   // register bus widths
   localparam int addr_w = 8;
   localparam int data_w = 32;

   // each channel owns a block of four consecutive addresses
   localparam logic [addr_w-1:0] regs_per_unit = 8'd4;

   // offsets within a channel block
   localparam logic [addr_w-1:0] reg_period  = 8'd0;
   localparam logic [addr_w-1:0] reg_on_time = 8'd1;
   localparam logic [addr_w-1:0] reg_config  = 8'd2;
   // read-only, number of completed periods
   localparam logic [addr_w-1:0] reg_status  = 8'd3;

   /*
    * config register word. The bus side moves it as a plain word, the
    * timer looks at the individual control bits.
    */
   typedef union packed {
      logic [data_w-1:0] raw;
      struct packed {
         logic [data_w-3:0] reserved;
         // 1 selects an active-low pulse
         logic              polarity;
         logic              enable;
      } fields;
   } pwm_config_u;

endpackage

//--- verilog/bus_handshake.sv
/*
 * Four-phase req/ack slave for the PWM register bus. Issues a one-cycle
 * write strobe to the channels and returns the read word of whichever
 * channel decodes the address, or zero when none does.
 */
`timescale 1ns/1ps

module bus_handshake (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  logic                      rw,
   output logic                      wr_stb,
   input  logic                      hit_0,
   input  logic                      hit_1,
   input  logic [pwm_pkg::data_w-1:0] rdata_0,
   input  logic [pwm_pkg::data_w-1:0] rdata_1,
   output logic                      ack,
   output logic [pwm_pkg::data_w-1:0] rdata
);

   localparam logic [1:0] idle_st   = 2'd0;
   localparam logic [1:0] access_st = 2'd1;
   localparam logic [1:0] ack_st    = 2'd2;

   logic [1:0]                 state;
   logic [pwm_pkg::data_w-1:0] read_mux;

   // unmapped addresses read as zero
   assign read_mux = hit_0 ? rdata_0 : (hit_1 ? rdata_1 : '0);

   assign wr_stb = (state == access_st) && rw;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= idle_st;
         ack   <= 1'b0;
         rdata <= '0;
      end else begin
         case (state)
            idle_st: begin
               if (req) begin
                  state <= access_st;
               end
            end
            access_st: begin
               state <= ack_st;
               if (!rw) begin
                  rdata <= read_mux;
               end
            end
            ack_st: begin
               // hold ack for as long as the master keeps req up
               if (req) begin
                  ack <= 1'b1;
               end else begin
                  ack   <= 1'b0;
                  state <= idle_st;
               end
            end
            default: state <= idle_st;
         endcase
      end
   end

   // channel blocks must never overlap
   a_one_hit: assert property (@(posedge clk) disable iff (!reset) !(hit_0 && hit_1));

   a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
      $rose(ack) |-> $past(req));

   // strobe only while an accepted request still waits for its ack
   a_stb_in_access: assert property (@(posedge clk) disable iff (!reset)
      wr_stb |-> req && !ack);

endmodule

//--- verilog/pwm_timer.sv
/*
 * Pulse generator for one PWM channel. Period and on-time are copied into
 * down-counters at every period start, so new values only take effect on
 * the next period. Also counts completed periods for the status register.
 */
`timescale 1ns/1ps

module pwm_timer (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [pwm_pkg::data_w-1:0]  period,
   input  logic [pwm_pkg::data_w-1:0]  on_time,
   input  pwm_pkg::pwm_config_u        pwm_config,
   output logic                        pwm,
   output logic [pwm_pkg::data_w-1:0]  done_count
);

   localparam logic idle_st = 1'b0;
   localparam logic run_st  = 1'b1;

   logic                       state;
   logic [pwm_pkg::data_w-1:0] per_cnt;
   logic [pwm_pkg::data_w-1:0] on_cnt;
   logic                       enable;
   logic                       enable_q;
   logic                       period_end;
   logic                       reload;
   logic                       active;

   assign enable = pwm_config.fields.enable;

   // last cycle of the running period
   assign period_end = (state == run_st) && (per_cnt == 1);

   // a zero period keeps the channel parked at idle
   assign reload = enable && (period != '0) && ((state == idle_st) || period_end);

   assign active = (state == run_st) && (on_cnt != '0);
   assign pwm    = active ^ pwm_config.fields.polarity;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= idle_st;
      end else begin
         if (!enable) begin
            state <= idle_st;
         end else if (reload) begin
            state <= run_st;
         end else if (period_end) begin
            state <= idle_st;
         end
      end
   end

   // working copies of period and on-time
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         per_cnt <= '0;
         on_cnt  <= '0;
      end else begin
         if (reload) begin
            per_cnt <= period;
            on_cnt  <= on_time;
         end else if (state == run_st && enable) begin
            per_cnt <= per_cnt - 1;
            if (on_cnt != '0) begin
               on_cnt <= on_cnt - 1;
            end
         end
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         enable_q   <= 1'b0;
         done_count <= '0;
      end else begin
         enable_q <= enable;
         if (enable && !enable_q) begin
            done_count <= '0;
         end else if (enable && period_end) begin
            done_count <= done_count + 1;
         end
      end
   end

   // once the active phase is used up it stays used up until the next reload
   a_on_no_wrap: assert property (@(posedge clk) disable iff (!reset)
      (state == run_st && on_cnt == '0 && !reload) |=> on_cnt == '0);

endmodule

//--- verilog/pwm_channel.sv
/*
 * One PWM channel: four registers at pwm_base + unit * regs_per_unit,
 * the address decode that claims them, and the pulse timer they drive.
 * Read data is combinational, the bus block registers it.
 */
`timescale 1ns/1ps

module pwm_channel #(
   parameter logic [pwm_pkg::addr_w-1:0] pwm_base = 8'd16,
   parameter int                         unit     = 0
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [pwm_pkg::addr_w-1:0]  addr,
   input  logic [pwm_pkg::data_w-1:0]  wdata,
   input  logic                        wr_stb,
   output logic                        hit,
   output logic [pwm_pkg::data_w-1:0]  rdata,
   output logic                        pwm
);

   localparam int blk_lo = int'(pwm_base) + unit * int'(pwm_pkg::regs_per_unit);
   localparam logic [pwm_pkg::addr_w-1:0] blk_base = blk_lo[pwm_pkg::addr_w-1:0];

   logic [pwm_pkg::addr_w-1:0] offset;
   logic [pwm_pkg::data_w-1:0] period;
   logic [pwm_pkg::data_w-1:0] on_time;
   pwm_pkg::pwm_config_u       cfg;
   logic [pwm_pkg::data_w-1:0] status;

   // wraps for addresses below the block, so a single compare covers both ends
   assign offset = addr - blk_base;
   assign hit    = offset < pwm_pkg::regs_per_unit;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period  <= '0;
         on_time <= '0;
         cfg.raw <= '0;
      end else begin
         if (wr_stb && hit) begin
            case (offset)
               pwm_pkg::reg_period:  period  <= wdata;
               pwm_pkg::reg_on_time: on_time <= wdata;
               pwm_pkg::reg_config:  cfg.raw <= wdata;
               // status is read-only
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      rdata = '0;
      case (offset)
         pwm_pkg::reg_period:  rdata = period;
         pwm_pkg::reg_on_time: rdata = on_time;
         pwm_pkg::reg_config:  rdata = cfg.raw;
         pwm_pkg::reg_status:  rdata = status;
         default:              rdata = '0;
      endcase
   end

   pwm_timer timer_i (
      .clk        (clk),
      .reset      (reset),
      .period     (period),
      .on_time    (on_time),
      .pwm_config (cfg),
      .pwm        (pwm),
      .done_count (status)
   );

   // bus write reaches the config register the timer sees
   a_cfg_write: assert property (@(posedge clk) disable iff (!reset)
      (wr_stb && hit && offset == pwm_pkg::reg_config) |=> cfg.raw == $past(wdata));

endmodule

//--- verilog/pwm_subsystem.sv
/*
 * Top level of the two-channel PWM peripheral. The handshake block serves
 * the req/ack register bus, both channels decode the shared address and
 * write data, and each drives its own pwm output.
 */
`timescale 1ns/1ps

module pwm_subsystem #(
   parameter logic [pwm_pkg::addr_w-1:0] pwm_base = 8'd16
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        req,
   input  logic                        rw,
   input  logic [pwm_pkg::addr_w-1:0]  addr,
   input  logic [pwm_pkg::data_w-1:0]  wdata,
   output logic                        ack,
   output logic [pwm_pkg::data_w-1:0]  rdata,
   output logic                        pwm_0,
   output logic                        pwm_1
);

   logic                       wr_stb;
   logic                       hit_0;
   logic                       hit_1;
   logic [pwm_pkg::data_w-1:0] rdata_0;
   logic [pwm_pkg::data_w-1:0] rdata_1;

   bus_handshake bus_i (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .rw      (rw),
      .wr_stb  (wr_stb),
      .hit_0   (hit_0),
      .hit_1   (hit_1),
      .rdata_0 (rdata_0),
      .rdata_1 (rdata_1),
      .ack     (ack),
      .rdata   (rdata)
   );

   pwm_channel #(.pwm_base(pwm_base), .unit(0)) chan_0_i (
      .clk    (clk),
      .reset  (reset),
      .addr   (addr),
      .wdata  (wdata),
      .wr_stb (wr_stb),
      .hit    (hit_0),
      .rdata  (rdata_0),
      .pwm    (pwm_0)
   );

   pwm_channel #(.pwm_base(pwm_base), .unit(1)) chan_1_i (
      .clk    (clk),
      .reset  (reset),
      .addr   (addr),
      .wdata  (wdata),
      .wr_stb (wr_stb),
      .hit    (hit_1),
      .rdata  (rdata_1),
      .pwm    (pwm_1)
   );

endmodule

//--- sim/tb_pwm_subsystem.sv
/*
 * Directed testbench for the two-channel PWM peripheral. Drives the req/ack
 * register bus from falling clock edges, measures the pulse runs on both
 * outputs and checks them against the programmed period, on-time and polarity.
 */
`timescale 1ns/1ps

module tb_pwm_subsystem;

   localparam logic [7:0] base_addr = 8'd16;

   logic        clk = 1'b0;
   logic        reset;
   logic        req;
   logic        rw;
   logic [7:0]  addr;
   logic [31:0] wdata;
   logic        ack;
   logic [31:0] rdata;
   logic        pwm_0;
   logic        pwm_1;

   int          errors = 0;
   // cycle limit for bus traffic, each pwm test raises it by its period lengths
   int          budget = 800;
   logic [31:0] lfsr = 32'h205d491b;
   logic [31:0] regs [2][3];

   pwm_subsystem dut_i (
      .clk(clk), .reset(reset), .req(req), .rw(rw), .addr(addr), .wdata(wdata),
      .ack(ack), .rdata(rdata), .pwm_0(pwm_0), .pwm_1(pwm_1)
   );

   always #5 clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic level(input int ch);
      return (ch == 0) ? pwm_0 : pwm_1;
   endfunction

   function automatic logic [7:0] reg_addr(input int ch, input logic [7:0] off);
      return base_addr + 8'(ch) * pwm_pkg::regs_per_unit + off;
   endfunction

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   // full four-phase access that keeps req up for hold cycles after ack
   task automatic bus_access(input logic is_write, input logic [7:0] a,
                             input logic [31:0] wd, input int hold, output logic [31:0] rd);
      int lat;
      req = 1'b1;
      rw = is_write;
      addr = a;
      wdata = wd;
      lat = 0;
      while (ack !== 1'b1 && lat < 16) begin
         @(negedge clk);
         lat++;
      end
      assert (ack === 1'b1) else begin
         errors++;
         $display("no ack for bus access to address 0x%02h", a);
      end
      // ack is due on the third falling edge after req goes up
      expect_value("ack latency", lat, 3);
      rd = rdata;
      repeat (hold) begin
         @(negedge clk);
         expect_value("ack", {31'b0, ack}, 1);
      end
      expect_value("rdata", rdata, rd);
      req = 1'b0;
      @(negedge clk);
      expect_value("ack", {31'b0, ack}, 0);
   endtask

   task automatic bus_write(input logic [7:0] a, input logic [31:0] wd);
      logic [31:0] unused;
      bus_access(1'b1, a, wd, 0, unused);
   endtask

   task automatic read_check(input logic [7:0] a, input logic [31:0] exp, input string name);
      logic [31:0] rd;
      bus_access(1'b0, a, '0, 2, rd);
      expect_value(name, rd, exp);
   endtask

   task automatic set_channel(input int ch, input logic [31:0] per, input logic [31:0] on,
                              input logic [31:0] cfg);
      bus_write(reg_addr(ch, pwm_pkg::reg_config), 32'h0);
      bus_write(reg_addr(ch, pwm_pkg::reg_period), per);
      bus_write(reg_addr(ch, pwm_pkg::reg_on_time), on);
      bus_write(reg_addr(ch, pwm_pkg::reg_config), cfg);
   endtask

   // number of samples at lvl before the level changes
   task automatic run_length(input int ch, input logic lvl, output int len);
      len = 0;
      while (level(ch) === lvl && len < 64) begin
         len++;
         @(negedge clk);
      end
      assert (len < 64) else begin
         errors++;
         $display("pwm_%0d stuck at level %0b", ch, lvl);
      end
   endtask

   task automatic measure_duty(input int ch, input int per, input int on, input logic pol,
                               input int n);
      int act_len;
      int idle_len;
      // skip the period already in progress
      run_length(ch, ~pol, act_len);
      run_length(ch, pol, idle_len);
      for (int i = 0; i < n; i++) begin
         run_length(ch, ~pol, act_len);
         run_length(ch, pol, idle_len);
         expect_value($sformatf("pwm_%0d active run", ch), act_len, (on < per) ? on : per);
         expect_value($sformatf("pwm_%0d period", ch), act_len + idle_len, per);
      end
   endtask

   task automatic watch_level(input int ch, input logic lvl, input int n);
      logic bad;
      bad = 1'b0;
      repeat (n) begin
         @(negedge clk);
         if (!bad && level(ch) !== lvl) begin
            bad = 1'b1;
            expect_value($sformatf("pwm_%0d", ch), {31'b0, level(ch)}, {31'b0, lvl});
         end
      end
   endtask

   task automatic reset_and_handshake();
      logic [31:0] rd;
      expect_value("ack", {31'b0, ack}, 0);
      expect_value("rdata", rdata, 0);
      expect_value("pwm_0", {31'b0, pwm_0}, 0);
      expect_value("pwm_1", {31'b0, pwm_1}, 0);
      // long hold so ack has to wait for req to drop
      bus_access(1'b0, reg_addr(0, pwm_pkg::reg_status), '0, 5, rd);
      expect_value("rdata", rd, 0);
   endtask

   task automatic register_readback();
      for (int ch = 0; ch < 2; ch++) begin
         for (int r = 0; r < 3; r++) begin
            regs[ch][r] = rand_bits(32);
            bus_write(reg_addr(ch, 8'(r)), regs[ch][r]);
         end
      end
      // just below and just above the two blocks
      bus_write(base_addr - 8'd1, rand_bits(32));
      bus_write(base_addr + 8'd8, rand_bits(32));
      read_check(base_addr - 8'd1, '0, "rdata unmapped low");
      read_check(base_addr + 8'd8, '0, "rdata unmapped high");
      for (int ch = 0; ch < 2; ch++) begin
         for (int r = 0; r < 3; r++) begin
            read_check(reg_addr(ch, 8'(r)), regs[ch][r], $sformatf("rdata ch%0d reg %0d", ch, r));
         end
      end
   endtask

   task automatic duty_both_channels();
      int per [2];
      int on [2];
      for (int ch = 0; ch < 2; ch++) begin
         per[ch] = 3 + int'(rand_bits(3));
         on[ch] = 1 + int'(rand_bits(4)) % (per[ch] - 1);
         budget += 8 * per[ch];
         set_channel(ch, per[ch], on[ch], 32'h1);
      end
      fork
         measure_duty(0, per[0], on[0], 1'b0, 4);
         measure_duty(1, per[1], on[1], 1'b0, 4);
      join
   endtask

   task automatic edge_cases_polarity();
      int per;
      int on;
      per = 3 + int'(rand_bits(3));
      on = 1 + int'(rand_bits(4)) % (per - 1);
      budget += 12 * per;
      bus_write(reg_addr(1, pwm_pkg::reg_config), 32'h0);
      bus_write(reg_addr(0, pwm_pkg::reg_config), 32'h0);
      watch_level(0, 1'b0, 8);
      bus_write(reg_addr(0, pwm_pkg::reg_config), 32'h2);
      watch_level(0, 1'b1, 8);
      set_channel(0, per, 0, 32'h1);
      watch_level(0, 1'b0, 2 * per);
      set_channel(0, per, per + int'(rand_bits(2)), 32'h1);
      watch_level(0, 1'b1, 2 * per);
      set_channel(0, per, on, 32'h3);
      measure_duty(0, per, on, 1'b1, 3);
      set_channel(1, per, 0, 32'h3);
      watch_level(1, 1'b1, 2 * per);
      bus_write(reg_addr(0, pwm_pkg::reg_config), 32'h0);
      bus_write(reg_addr(1, pwm_pkg::reg_config), 32'h0);
   endtask

   task automatic completed_count();
      int   per;
      int   want;
      int   seen;
      int   guard;
      logic prev;
      per = 4 + int'(rand_bits(2));
      want = 2 + int'(rand_bits(2));
      budget += per * (want + 4);
      set_channel(1, per, 1 + int'(rand_bits(1)), 32'h1);
      seen = 0;
      guard = 0;
      prev = pwm_1;
      // each new rising edge closes the period before it
      while (seen < want && guard < per * (want + 2)) begin
         @(negedge clk);
         if (!prev && pwm_1) begin
            seen++;
         end
         prev = pwm_1;
         guard++;
      end
      assert (seen == want) else begin
         errors++;
         $display("pwm_1 showed %0d of %0d period starts", seen, want);
      end
      bus_write(reg_addr(1, pwm_pkg::reg_config), 32'h0);
      read_check(reg_addr(1, pwm_pkg::reg_status), want, "rdata status");
      bus_write(reg_addr(1, pwm_pkg::reg_config), 32'h1);
      read_check(reg_addr(1, pwm_pkg::reg_status), '0, "rdata status");
      bus_write(reg_addr(1, pwm_pkg::reg_config), 32'h0);
   endtask

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < budget) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, tests did not finish", cycles);
      $display("errors: %0d", errors);
      $display("sim failed");
      $finish;
   end

   initial begin
      req = 1'b0;
      rw = 1'b0;
      addr = '0;
      wdata = '0;
      reset = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      reset_and_handshake();
      register_readback();
      duty_both_channels();
      edge_cases_polarity();
      completed_count();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- files.f
verilog/pwm_pkg.sv
verilog/bus_handshake.sv
verilog/pwm_timer.sv
verilog/pwm_channel.sv
verilog/pwm_subsystem.sv
sim/tb_pwm_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the PWM testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pwm_subsystem -f files.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vtb_pwm_subsystem)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
   exit 0
fi
echo "pass message not found"
exit 1
